// ==== build.sh ====
#!/usr/bin/env bash
# Build the core_block testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_core_block -f core_block.f \
  -o tb_core_block \
  && ./obj_dir/tb_core_block > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== core_block.f ====
source/core_block_pkg.sv
source/mem_router.sv
source/data_mem.sv
source/bc_msg_gen.sv
source/accel_unit.sv
source/core_block.sv
test/tb_core_block.sv

// ==== source/accel_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module accel_unit import core_block_pkg::*; (
  input  wire                  sys_clk,
  input  wire                  rst_n,
  input  wire                  exio_en,
  input  wire mem_req_t        core_req,
  output logic [31:0]          exio_rd_data,
  output logic                 exio_rd_valid,
  output logic                 acc_rd_en,
  output logic [7:0]           acc_rd_line,
  input  wire                  acc_rd_grant,
  input  wire                  acc_rd_valid,
  input  wire [DATA_WIDTH-1:0] acc_rd_data
);

  typedef enum logic [1:0] {ENG_IDLE, ENG_REQ, ENG_WAIT} eng_state_t;

  eng_state_t  state;
  acc_op_t     op;
  logic [7:0]  src_line;
  logic [8:0]  len;
  logic [31:0] result;
  logic [7:0]  line_ptr;
  logic [8:0]  remaining;
  logic        busy;
  logic [2:0]  reg_off;
  logic        reg_wr;
  logic        ctrl_wr;
  acc_op_t     new_op;

  // Fold the four words of a line into the running value
  function automatic logic [31:0] fold_line(input acc_op_t f_op, input logic [31:0] acc,
                                            input logic [DATA_WIDTH-1:0] line);
    logic [31:0] r;
    r = acc;
    for (int i = 0; i < 4; i++) begin
      if (f_op == ACC_XOR) begin
        r = r ^ line[32*i +: 32];
      end else begin
        r = r + line[32*i +: 32];
      end
    end
    return r;
  endfunction

  assign busy     = (state != ENG_IDLE);
  assign reg_off  = core_req.addr[4:2];
  assign reg_wr   = exio_en && core_req.wen;
  assign ctrl_wr  = reg_wr && (reg_off == ACC_REG_CTRL);
  assign new_op   = acc_op_t'(core_req.wr_data[1:0]);

  assign acc_rd_en   = (state == ENG_REQ);
  assign acc_rd_line = line_ptr;

  ////////////////////////////////////////
  // Register reads
  ////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    case (reg_off)
      ACC_REG_SRC:  exio_rd_data <= {24'd0, src_line};
      ACC_REG_LEN:  exio_rd_data <= {23'd0, len};
      ACC_REG_CTRL: exio_rd_data <= {30'd0, op};
      ACC_REG_STAT: exio_rd_data <= {31'd0, busy};
      ACC_REG_RES:  exio_rd_data <= result;
      default:      exio_rd_data <= 32'd0;
    endcase
  end

  ////////////////////////////////////////
  // Registers and line engine
  ////////////////////////////////////////
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= ENG_IDLE;
      op            <= ACC_IDLE;
      src_line      <= 8'd0;
      len           <= 9'd0;
      result        <= 32'd0;
      line_ptr      <= 8'd0;
      remaining     <= 9'd0;
      exio_rd_valid <= 1'b0;
    end else begin
      exio_rd_valid <= exio_en && !core_req.wen;
      if (reg_wr && reg_off == ACC_REG_SRC) begin
        src_line <= core_req.wr_data[7:0];
      end
      if (reg_wr && reg_off == ACC_REG_LEN) begin
        len <= core_req.wr_data[8:0];
      end
      // A CTRL write restarts; a read still in flight is dropped
      if (ctrl_wr) begin
        op        <= new_op;
        result    <= 32'd0;
        line_ptr  <= src_line;
        remaining <= len;
        if ((new_op == ACC_SUM || new_op == ACC_XOR) && len != 9'd0) begin
          state <= ENG_REQ;
        end else begin
          state <= ENG_IDLE;
        end
      end else if (state == ENG_REQ && acc_rd_grant) begin
        line_ptr <= line_ptr + 8'd1;
        state    <= ENG_WAIT;
      end else if (state == ENG_WAIT && acc_rd_valid) begin
        result    <= fold_line(op, result, acc_rd_data);
        remaining <= remaining - 9'd1;
        state     <= (remaining == 9'd1) ? ENG_IDLE : ENG_REQ;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/bc_msg_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module bc_msg_gen import core_block_pkg::*; #(
  parameter int BC_START_ADDR = 3840
) (
  input  wire             sys_clk,
  input  wire             rst_n,
  input  wire             bc_wr,
  input  wire mem_req_t   core_req,
  output bc_msg_t         bc_msg_out,
  output logic            bc_msg_out_valid,
  input  wire             bc_msg_out_ready,
  output logic            core_msg_ready
);

  logic [ADDR_WIDTH-1:0] bc_offset;
  bc_msg_t               new_msg;
  bc_msg_t               queue [2];
  logic                  wr_ptr;
  logic                  rd_ptr;
  logic [1:0]            count;
  logic                  fifo_full;
  logic                  push;
  logic                  pop;

  // Word index relative to the region base
  assign bc_offset    = core_req.addr - ADDR_WIDTH'(BC_START_ADDR);
  assign new_msg.idx  = bc_offset[MSG_ADDR_WIDTH+1:2];
  assign new_msg.strb = core_req.strb;
  assign new_msg.data = core_req.wr_data;

  assign fifo_full = (count == 2'd2);
  assign push      = bc_wr && !fifo_full;
  assign pop       = bc_msg_out_valid && bc_msg_out_ready;

  assign bc_msg_out       = queue[rd_ptr];
  assign bc_msg_out_valid = (count != 2'd0);
  assign core_msg_ready   = !fifo_full;

  ////////////////////////////////////////
  // Two-entry FIFO
  ////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (push) begin
      queue[wr_ptr] <= new_msg;
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  // Core must respect core_msg_ready before writing the region
  a_no_push_when_full: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    bc_wr |-> !fifo_full
  );

endmodule

`default_nettype wire

// ==== source/core_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_block import core_block_pkg::*; #(
  parameter int DMEM_LINES     = 256,
  parameter int BC_REGION_SIZE = 256
) (
  input  wire                sys_clk,
  input  wire                rst_n,

  // Core data bus
  input  wire mem_req_t      core_req,
  output logic [31:0]        core_rd_data,
  output logic               core_rd_valid,
  output logic               core_msg_ready,

  // DMA line writes
  input  wire dma_wr_t       dma_wr,
  input  wire                dma_wr_en,
  output logic               dma_wr_ready,

  // Broadcast messages
  input  wire bc_msg_t       bc_msg_in,
  input  wire                bc_msg_in_valid,
  output bc_msg_t            bc_msg_out,
  output logic               bc_msg_out_valid,
  input  wire                bc_msg_out_ready
);

  // Broadcast region sits at the top of local memory
  localparam int BC_START_ADDR = DMEM_LINES * 16 - BC_REGION_SIZE;

  logic                  dmem_en;
  logic                  exio_en;
  logic                  bc_wr;
  logic [31:0]           dmem_rd_data;
  logic                  dmem_rd_valid;
  logic [31:0]           exio_rd_data;
  logic                  exio_rd_valid;

  logic                  acc_rd_en;
  logic [7:0]            acc_rd_line;
  logic                  acc_rd_grant;
  logic                  acc_rd_valid;
  logic [DATA_WIDTH-1:0] acc_rd_data;

  ////////////////////////////////////////
  // Request decode and return merge
  ////////////////////////////////////////
  mem_router #(
    .DMEM_LINES    (DMEM_LINES),
    .BC_START_ADDR (BC_START_ADDR)
  ) router_inst (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .core_req      (core_req),
    .dmem_en       (dmem_en),
    .exio_en       (exio_en),
    .bc_wr         (bc_wr),
    .dmem_rd_data  (dmem_rd_data),
    .exio_rd_data  (exio_rd_data),
    .dmem_rd_valid (dmem_rd_valid),
    .exio_rd_valid (exio_rd_valid),
    .core_rd_data  (core_rd_data),
    .core_rd_valid (core_rd_valid)
  );

  ////////////////////////////////////////
  // Local memory
  ////////////////////////////////////////
  data_mem #(
    .DMEM_LINES      (DMEM_LINES),
    .BC_START_ADDR   (BC_START_ADDR)
  ) dmem_inst (
    .sys_clk         (sys_clk),
    .rst_n           (rst_n),
    .dmem_en         (dmem_en),
    .core_req        (core_req),
    .dmem_rd_data    (dmem_rd_data),
    .dmem_rd_valid   (dmem_rd_valid),
    .dma_wr          (dma_wr),
    .dma_wr_en       (dma_wr_en),
    .dma_wr_ready    (dma_wr_ready),
    .bc_msg_in       (bc_msg_in),
    .bc_msg_in_valid (bc_msg_in_valid),
    .acc_rd_en       (acc_rd_en),
    .acc_rd_line     (acc_rd_line),
    .acc_rd_grant    (acc_rd_grant),
    .acc_rd_valid    (acc_rd_valid),
    .acc_rd_data     (acc_rd_data)
  );

  ////////////////////////////////////////
  // Outgoing messages and accelerator
  ////////////////////////////////////////
  bc_msg_gen #(
    .BC_START_ADDR    (BC_START_ADDR)
  ) msg_gen_inst (
    .sys_clk          (sys_clk),
    .rst_n            (rst_n),
    .bc_wr            (bc_wr),
    .core_req         (core_req),
    .bc_msg_out       (bc_msg_out),
    .bc_msg_out_valid (bc_msg_out_valid),
    .bc_msg_out_ready (bc_msg_out_ready),
    .core_msg_ready   (core_msg_ready)
  );

  accel_unit accel_inst (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .exio_en       (exio_en),
    .core_req      (core_req),
    .exio_rd_data  (exio_rd_data),
    .exio_rd_valid (exio_rd_valid),
    .acc_rd_en     (acc_rd_en),
    .acc_rd_line   (acc_rd_line),
    .acc_rd_grant  (acc_rd_grant),
    .acc_rd_valid  (acc_rd_valid),
    .acc_rd_data   (acc_rd_data)
  );

endmodule

`default_nettype wire

// ==== source/core_block_pkg.sv ====
`default_nettype none

package core_block_pkg;

  ////////////////////////////////////////
  // Widths and memory map
  ////////////////////////////////////////
  localparam int DATA_WIDTH     = 128;
  localparam int STRB_WIDTH     = 16;
  localparam int ADDR_WIDTH     = 25;
  localparam int MSG_ADDR_WIDTH = 6;

  // Address bit that opens the accelerator window
  localparam int EXIO_BIT = 24;

  // Accelerator register word offsets
  localparam logic [2:0] ACC_REG_SRC  = 3'd0;
  localparam logic [2:0] ACC_REG_LEN  = 3'd1;
  localparam logic [2:0] ACC_REG_CTRL = 3'd2;
  localparam logic [2:0] ACC_REG_STAT = 3'd3;
  localparam logic [2:0] ACC_REG_RES  = 3'd4;

  ////////////////////////////////////////
  // Bus and message types
  ////////////////////////////////////////
  typedef struct packed {
    logic                  en;
    logic                  wen;
    logic [3:0]            strb;
    logic [ADDR_WIDTH-1:0] addr;
    logic [31:0]           wr_data;
  } mem_req_t;

  // Word index on top, then strobe, then data
  typedef struct packed {
    logic [MSG_ADDR_WIDTH-1:0] idx;
    logic [3:0]                strb;
    logic [31:0]               data;
  } bc_msg_t;

  typedef struct packed {
    logic [7:0]            line_addr;
    logic [STRB_WIDTH-1:0] strb;
    logic [DATA_WIDTH-1:0] data;
  } dma_wr_t;

  typedef enum logic [1:0] {REG_DMEM, REG_BC, REG_EXIO, REG_NONE} region_t;

  typedef enum logic [1:0] {ACC_IDLE, ACC_SUM, ACC_XOR} acc_op_t;

endpackage

`default_nettype wire

// ==== source/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem import core_block_pkg::*; #(
  parameter int DMEM_LINES    = 256,
  parameter int BC_START_ADDR = 3840
) (
  input  wire                   sys_clk,
  input  wire                   rst_n,

  // Core word port
  input  wire                   dmem_en,
  input  wire mem_req_t         core_req,
  output logic [31:0]           dmem_rd_data,
  output logic                  dmem_rd_valid,

  // Line port
  input  wire dma_wr_t          dma_wr,
  input  wire                   dma_wr_en,
  output logic                  dma_wr_ready,
  input  wire bc_msg_t          bc_msg_in,
  input  wire                   bc_msg_in_valid,
  input  wire                   acc_rd_en,
  input  wire [7:0]             acc_rd_line,
  output logic                  acc_rd_grant,
  output logic                  acc_rd_valid,
  output logic [DATA_WIDTH-1:0] acc_rd_data
);

  localparam int LINE_AW = $clog2(DMEM_LINES);
  localparam logic [LINE_AW-1:0] BC_LINE0 = LINE_AW'(BC_START_ADDR / 16);

  logic [DATA_WIDTH-1:0] mem [DMEM_LINES];

  logic [LINE_AW-1:0]    core_line;
  logic [1:0]            core_word;
  logic                  core_we;
  logic [STRB_WIDTH-1:0] core_strb;
  logic [DATA_WIDTH-1:0] core_wdata;

  logic [LINE_AW-1:0]    msg_line;
  logic [STRB_WIDTH-1:0] msg_strb;

  logic                  lp_we;
  logic [LINE_AW-1:0]    lp_addr;
  logic [STRB_WIDTH-1:0] lp_strb;
  logic [DATA_WIDTH-1:0] lp_data;

  ////////////////////////////////////////
  // Core word port
  ////////////////////////////////////////
  assign core_line  = core_req.addr[LINE_AW+3:4];
  assign core_word  = core_req.addr[3:2];
  assign core_we    = dmem_en && core_req.wen;
  assign core_strb  = STRB_WIDTH'(core_req.strb) << (core_word * 4);
  assign core_wdata = {4{core_req.wr_data}};

  ////////////////////////////////////////
  // Line port arbitration
  ////////////////////////////////////////
  // Four message words per line, starting at the region base
  assign msg_line = BC_LINE0 + LINE_AW'(bc_msg_in.idx[MSG_ADDR_WIDTH-1:2]);
  assign msg_strb = STRB_WIDTH'(bc_msg_in.strb) << (bc_msg_in.idx[1:0] * 4);

  assign dma_wr_ready = !bc_msg_in_valid;
  assign acc_rd_grant = acc_rd_en && !bc_msg_in_valid && !dma_wr_en;

  // Message first, then DMA
  always_comb begin
    lp_we   = 1'b0;
    lp_addr = msg_line;
    lp_strb = msg_strb;
    lp_data = {4{bc_msg_in.data}};
    if (bc_msg_in_valid) begin
      lp_we = 1'b1;
    end else if (dma_wr_en) begin
      lp_we   = 1'b1;
      lp_addr = dma_wr.line_addr[LINE_AW-1:0];
      lp_strb = dma_wr.strb;
      lp_data = dma_wr.data;
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (lp_we && lp_strb[b]) begin
        mem[lp_addr][8*b +: 8] <= lp_data[8*b +: 8];
      end
      // core byte wins if both ports hit it
      if (core_we && core_strb[b]) begin
        mem[core_line][8*b +: 8] <= core_wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    dmem_rd_data <= mem[core_line][32*core_word +: 32];
    acc_rd_data  <= mem[acc_rd_line[LINE_AW-1:0]];
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      dmem_rd_valid <= 1'b0;
      acc_rd_valid  <= 1'b0;
    end else begin
      dmem_rd_valid <= dmem_en && !core_req.wen;
      acc_rd_valid  <= acc_rd_grant;
    end
  end

endmodule

`default_nettype wire

// ==== source/mem_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_router import core_block_pkg::*; #(
  parameter int DMEM_LINES    = 256,
  parameter int BC_START_ADDR = 3840
) (
  input  wire             sys_clk,
  input  wire             rst_n,
  input  wire mem_req_t   core_req,
  output logic            dmem_en,
  output logic            exio_en,
  output logic            bc_wr,
  input  wire [31:0]      dmem_rd_data,
  input  wire [31:0]      exio_rd_data,
  input  wire             dmem_rd_valid,
  input  wire             exio_rd_valid,
  output logic [31:0]     core_rd_data,
  output logic            core_rd_valid
);

  localparam logic [ADDR_WIDTH-1:0] DMEM_END = ADDR_WIDTH'(DMEM_LINES * 16);
  localparam logic [ADDR_WIDTH-1:0] BC_START = ADDR_WIDTH'(BC_START_ADDR);

  region_t region;

  // Region decode, accelerator window takes precedence
  always_comb begin
    if (core_req.addr[EXIO_BIT]) begin
      region = REG_EXIO;
    end else if (core_req.addr >= DMEM_END) begin
      region = REG_NONE;
    end else if (core_req.addr >= BC_START) begin
      region = REG_BC;
    end else begin
      region = REG_DMEM;
    end
  end

  // Broadcast writes also land in local memory
  assign dmem_en = core_req.en && (region == REG_DMEM || region == REG_BC);
  assign exio_en = core_req.en && (region == REG_EXIO);
  assign bc_wr   = core_req.en && core_req.wen && (region == REG_BC);

  ////////////////////////////////////////
  // Return merge
  ////////////////////////////////////////
  assign core_rd_data  = exio_rd_valid ? exio_rd_data : dmem_rd_data;
  assign core_rd_valid = dmem_rd_valid | exio_rd_valid;

  // Every read must hit a mapped region and be answered next cycle
  a_read_answered: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    (core_req.en && !core_req.wen) |-> (region != REG_NONE) ##1 core_rd_valid
  );

  // Memory and accelerator never return on the same cycle
  a_single_return: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    !(dmem_rd_valid && exio_rd_valid)
  );

endmodule

`default_nettype wire

// ==== test/tb_core_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core_block import core_block_pkg::*; ();

  localparam int DMEM_LINES     = 256;
  localparam int BC_REGION_SIZE = 256;
  localparam int BC_START       = DMEM_LINES * 16 - BC_REGION_SIZE;
  localparam int DATA_LINES     = BC_START / 16;
  localparam int TIMEOUT_CYCLES = 4000;
  localparam logic [ADDR_WIDTH-1:0] EXIO_BASE = ADDR_WIDTH'(1) << EXIO_BIT;

  logic        sys_clk;
  logic        rst_n;
  mem_req_t    core_req;
  logic [31:0] core_rd_data;
  logic        core_rd_valid;
  logic        core_msg_ready;
  dma_wr_t     dma_wr;
  logic        dma_wr_en;
  logic        dma_wr_ready;
  bc_msg_t     bc_msg_in;
  logic        bc_msg_in_valid;
  bc_msg_t     bc_msg_out;
  logic        bc_msg_out_valid;
  logic        bc_msg_out_ready;

  // Shadow copy of local memory with one entry per line
  logic [DATA_WIDTH-1:0] shadow [DMEM_LINES];

  logic [31:0] exp_rd_data [$];
  int          exp_rd_cycle [$];
  logic        exp_rd_chk [$];
  bc_msg_t     exp_msg [$];

  logic [31:0] rng_state = 32'h69e906c6;
  logic [31:0] last_rd_data;
  int          cycle = 0;
  int          errors = 0;
  int          reads_checked = 0;
  int          msgs_checked = 0;

  core_block #(
    .DMEM_LINES     (DMEM_LINES),
    .BC_REGION_SIZE (BC_REGION_SIZE)
  ) DUT (
    .sys_clk          (sys_clk),
    .rst_n            (rst_n),
    .core_req         (core_req),
    .core_rd_data     (core_rd_data),
    .core_rd_valid    (core_rd_valid),
    .core_msg_ready   (core_msg_ready),
    .dma_wr           (dma_wr),
    .dma_wr_en        (dma_wr_en),
    .dma_wr_ready     (dma_wr_ready),
    .bc_msg_in        (bc_msg_in),
    .bc_msg_in_valid  (bc_msg_in_valid),
    .bc_msg_out       (bc_msg_out),
    .bc_msg_out_valid (bc_msg_out_valid),
    .bc_msg_out_ready (bc_msg_out_ready)
  );

  initial sys_clk = 1'b0;
  always #4 sys_clk = ~sys_clk;

  ////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] rand_line();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  // Word aligned and below the broadcast region
  function automatic logic [ADDR_WIDTH-1:0] rand_data_addr();
    return ADDR_WIDTH'((next_rand() % DATA_LINES) * 16 + (next_rand() % 4) * 4);
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] rand_bc_addr();
    return ADDR_WIDTH'(BC_START + (next_rand() % 64) * 4);
  endfunction

  function automatic logic [31:0] expected_word(input logic [ADDR_WIDTH-1:0] addr);
    return shadow[8'(addr >> 4)][32 * int'(addr[3:2]) +: 32];
  endfunction

  function automatic bc_msg_t expected_msg(input logic [ADDR_WIDTH-1:0] addr,
                                           input logic [3:0] strb, input logic [31:0] data);
    bc_msg_t m;
    m.idx  = MSG_ADDR_WIDTH'((int'(addr) - BC_START) / 4);
    m.strb = strb;
    m.data = data;
    return m;
  endfunction

  // Sum or XOR of every word in LEN lines from SRC
  function automatic logic [31:0] reduce_ref(input acc_op_t op, input logic [7:0] src,
                                             input int len);
    logic [31:0] acc;
    logic [7:0]  ln;
    acc = 32'd0;
    ln  = src;
    for (int n = 0; n < len; n++) begin
      for (int w = 0; w < 4; w++) begin
        if (op == ACC_SUM) begin
          acc = acc + shadow[ln][32*w +: 32];
        end else begin
          acc = acc ^ shadow[ln][32*w +: 32];
        end
      end
      ln = ln + 8'd1;
    end
    return acc;
  endfunction

  task automatic shadow_word_write(input logic [ADDR_WIDTH-1:0] addr, input logic [3:0] strb,
                                   input logic [31:0] data);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        shadow[8'(addr >> 4)][32 * int'(addr[3:2]) + 8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("%s (cycle %0d)", what, cycle);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("CHECK FAILED %s: got %h, expected %h (cycle %0d)", name, got, exp, cycle);
  endtask

  ////////////////////////////////////////
  // Bus drivers
  ////////////////////////////////////////
  task automatic drive_bus(input logic en, input logic wen, input logic [3:0] strb,
                           input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    @(posedge sys_clk);
    #1;
    core_req.en      = en;
    core_req.wen     = wen;
    core_req.strb    = strb;
    core_req.addr    = addr;
    core_req.wr_data = data;
  endtask

  task automatic bus_idle();
    drive_bus(1'b0, 1'b0, 4'h0, '0, 32'd0);
  endtask

  // Return expected in the cycle after the request
  task automatic expect_read(input logic chk, input logic [31:0] data);
    exp_rd_data.push_back(data);
    exp_rd_cycle.push_back(cycle + 1);
    exp_rd_chk.push_back(chk);
  endtask

  task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input logic [3:0] strb,
                            input logic [31:0] data);
    drive_bus(1'b1, 1'b1, strb, addr, data);
    shadow_word_write(addr, strb, data);
    if (int'(addr) >= BC_START) begin
      exp_msg.push_back(expected_msg(addr, strb, data));
    end
  endtask

  task automatic read_word(input logic [ADDR_WIDTH-1:0] addr);
    drive_bus(1'b1, 1'b0, 4'hf, addr, 32'd0);
    expect_read(1'b1, expected_word(addr));
  endtask

  task automatic read_line(input logic [ADDR_WIDTH-1:0] base);
    for (int w = 0; w < 4; w++) begin
      read_word(base + ADDR_WIDTH'(4 * w));
    end
  endtask

  task automatic acc_write(input logic [2:0] off, input logic [31:0] data);
    drive_bus(1'b1, 1'b1, 4'hf, EXIO_BASE | (ADDR_WIDTH'(off) << 2), data);
  endtask

  task automatic acc_read(input logic [2:0] off, input logic chk, input logic [31:0] exp,
                          output logic [31:0] data);
    drive_bus(1'b1, 1'b0, 4'hf, EXIO_BASE | (ADDR_WIDTH'(off) << 2), 32'd0);
    expect_read(chk, exp);
    bus_idle();
    @(negedge sys_clk);
    #1;
    data = last_rd_data;
  endtask

  // One line port cycle where a message blocks the DMA beat
  task automatic line_port_cycle(input logic msg_v, input bc_msg_t msg, input logic dma_v,
                                 input dma_wr_t beat, output logic taken);
    @(posedge sys_clk);
    #1;
    bc_msg_in_valid = msg_v;
    bc_msg_in       = msg;
    dma_wr_en       = dma_v;
    dma_wr          = beat;
    taken           = dma_v && !msg_v;
    if (msg_v) begin
      shadow_word_write(ADDR_WIDTH'(BC_START + 4 * int'(msg.idx)), msg.strb, msg.data);
    end
    if (taken) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (beat.strb[b]) begin
          shadow[beat.line_addr][8*b +: 8] = beat.data[8*b +: 8];
        end
      end
    end
  endtask

  task automatic run_accel(input acc_op_t op, input int len);
    logic [7:0]  src;
    logic [31:0] stat;
    int          polls;
    src   = 8'(next_rand() % 200);
    polls = 0;
    acc_write(ACC_REG_SRC, 32'(src));
    acc_write(ACC_REG_LEN, 32'(len));
    acc_write(ACC_REG_CTRL, 32'(op));
    do begin
      acc_read(ACC_REG_STAT, 1'b0, 32'd0, stat);
      polls++;
    end while (stat[0] && polls < 200);
    if (stat[0]) begin
      note_failure("Accelerator still busy after 200 status polls");
    end
    acc_read(ACC_REG_RES, 1'b1, reduce_ref(op, src, len), stat);
  endtask

  ////////////////////////////////////////
  // Cycle count and timeout
  ////////////////////////////////////////
  always @(posedge sys_clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycle);
      $display("Checks failed");
      $finish;
    end
  end

  // Outputs sampled on the falling edge
  always @(negedge sys_clk) begin : compare
    logic [31:0] e_data;
    int          e_cycle;
    logic        e_chk;
    bc_msg_t     e_msg;
    if (rst_n) begin
      if (core_rd_valid) begin
        last_rd_data = core_rd_data;
        if (exp_rd_data.size() == 0) begin
          note_failure("Read data returned with no read outstanding");
        end else begin
          e_data  = exp_rd_data.pop_front();
          e_cycle = exp_rd_cycle.pop_front();
          e_chk   = exp_rd_chk.pop_front();
          reads_checked++;
          if (cycle != e_cycle) begin
            note_failure("Read data returned in the wrong cycle");
          end
          if (e_chk && core_rd_data !== e_data) begin
            report_mismatch("core_rd_data", 64'(core_rd_data), 64'(e_data));
          end
        end
      end else if (exp_rd_cycle.size() != 0 && cycle >= exp_rd_cycle[0]) begin
        note_failure("Read data missing one cycle after the request");
        void'(exp_rd_data.pop_front());
        void'(exp_rd_cycle.pop_front());
        void'(exp_rd_chk.pop_front());
      end
      if (bc_msg_out_valid && bc_msg_out_ready) begin
        if (exp_msg.size() == 0) begin
          note_failure("Broadcast message sent that no core write produced");
        end else begin
          e_msg = exp_msg.pop_front();
          msgs_checked++;
          if (bc_msg_out !== e_msg) begin
            report_mismatch("bc_msg_out", 64'(bc_msg_out), 64'(e_msg));
          end
        end
      end
      // DMA ready is low exactly while a message is offered
      if (dma_wr_ready !== !bc_msg_in_valid) begin
        report_mismatch("dma_wr_ready", 64'(dma_wr_ready), 64'(!bc_msg_in_valid));
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin : stimulus
    logic                  taken;
    logic                  msg_v;
    logic [ADDR_WIDTH-1:0] addr;
    logic [ADDR_WIDTH-1:0] addr_q [$];
    logic [ADDR_WIDTH-1:0] line_q [$];
    dma_wr_t               beat;
    dma_wr_t               pend [$];
    bc_msg_t               msg;
    int                    i;

    rst_n            = 1'b0;
    core_req         = '0;
    dma_wr           = '0;
    dma_wr_en        = 1'b0;
    bc_msg_in        = '0;
    bc_msg_in_valid  = 1'b0;
    bc_msg_out_ready = 1'b0;
    repeat (2) @(posedge sys_clk);
    #1;
    rst_n = 1'b1;

    @(negedge sys_clk);
    if (core_rd_valid !== 1'b0) report_mismatch("core_rd_valid", 64'(core_rd_valid), 64'h0);
    if (bc_msg_out_valid !== 1'b0) begin
      report_mismatch("bc_msg_out_valid", 64'(bc_msg_out_valid), 64'h0);
    end
    if (core_msg_ready !== 1'b1) report_mismatch("core_msg_ready", 64'(core_msg_ready), 64'h1);

    // Fill every line so nothing reads back undefined
    for (i = 0; i < DMEM_LINES; i++) begin
      beat.line_addr = 8'(i);
      beat.strb      = 16'hffff;
      beat.data      = rand_line();
      line_port_cycle(1'b0, '0, 1'b1, beat, taken);
    end
    line_port_cycle(1'b0, '0, 1'b0, '0, taken);

    // Core word writes each read back in the next cycle
    for (i = 0; i < 32; i++) begin
      addr = rand_data_addr();
      write_word(addr, 4'(next_rand()), next_rand());
      read_word(addr);
      read_word(rand_data_addr());
    end
    bus_idle();

    // DMA beats under random line strobes
    for (i = 0; i < 24; i++) begin
      beat.line_addr = 8'(next_rand() % DATA_LINES);
      beat.strb      = 16'(next_rand());
      beat.data      = rand_line();
      line_port_cycle(1'b0, '0, 1'b1, beat, taken);
      line_q.push_back(ADDR_WIDTH'(beat.line_addr) << 4);
    end
    line_port_cycle(1'b0, '0, 1'b0, '0, taken);
    while (line_q.size() != 0) read_line(line_q.pop_front());
    bus_idle();

    ////////////////////////////////////////
    // Outgoing messages under back-pressure
    ////////////////////////////////////////
    addr_q.push_back(rand_bc_addr());
    addr_q.push_back(rand_bc_addr());
    write_word(addr_q[0], 4'(next_rand()), next_rand());
    @(negedge sys_clk);
    if (bc_msg_out_valid !== 1'b0) begin
      report_mismatch("bc_msg_out_valid", 64'(bc_msg_out_valid), 64'h0);
    end
    write_word(addr_q[1], 4'(next_rand()), next_rand());
    @(negedge sys_clk);
    if (bc_msg_out_valid !== 1'b1) begin
      report_mismatch("bc_msg_out_valid", 64'(bc_msg_out_valid), 64'h1);
    end
    bus_idle();
    repeat (4) begin
      @(negedge sys_clk);
      if (core_msg_ready !== 1'b0) begin
        report_mismatch("core_msg_ready", 64'(core_msg_ready), 64'h0);
      end
    end
    @(posedge sys_clk);
    #1;
    bc_msg_out_ready = 1'b1;
    while (exp_msg.size() != 0) @(negedge sys_clk);
    @(negedge sys_clk);
    if (core_msg_ready !== 1'b1) report_mismatch("core_msg_ready", 64'(core_msg_ready), 64'h1);

    // Back to back with the queue draining
    for (i = 0; i < 6; i++) begin
      addr = rand_bc_addr();
      addr_q.push_back(addr);
      write_word(addr, 4'(next_rand()), next_rand());
    end
    while (addr_q.size() != 0) read_word(addr_q.pop_front());
    bus_idle();

    ////////////////////////////////////////
    // Incoming messages against DMA beats
    ////////////////////////////////////////
    for (i = 0; i < 5; i++) begin
      beat.line_addr = 8'(next_rand() % DATA_LINES);
      beat.strb      = 16'(next_rand());
      beat.data      = rand_line();
      pend.push_back(beat);
    end
    i = 0;
    while (pend.size() != 0 || i < 12) begin
      msg_v    = (i < 12) && (i % 4 != 3);
      msg.idx  = MSG_ADDR_WIDTH'(next_rand());
      msg.strb = 4'(next_rand());
      msg.data = next_rand();
      if (msg_v) addr_q.push_back(ADDR_WIDTH'(BC_START + 4 * int'(msg.idx)));
      beat = '0;
      if (pend.size() != 0) beat = pend[0];
      line_port_cycle(msg_v, msg, pend.size() != 0, beat, taken);
      if (taken) begin
        line_q.push_back(ADDR_WIDTH'(beat.line_addr) << 4);
        void'(pend.pop_front());
      end
      i++;
    end
    line_port_cycle(1'b0, '0, 1'b0, '0, taken);
    while (addr_q.size() != 0) read_word(addr_q.pop_front());
    while (line_q.size() != 0) read_line(line_q.pop_front());
    bus_idle();

    // Accelerator jobs with a LEN of 0 among them
    run_accel(ACC_SUM, 0);
    run_accel(ACC_SUM, 1);
    run_accel(ACC_SUM, 4);
    run_accel(ACC_SUM, 7);
    run_accel(ACC_XOR, 0);
    run_accel(ACC_XOR, 3);
    run_accel(ACC_XOR, 8);

    bus_idle();
    repeat (4) @(posedge sys_clk);
    if (exp_rd_data.size() != 0) note_failure("Read returns still outstanding at the end");
    if (exp_msg.size() != 0) note_failure("Broadcast messages never left the DUT");
    $display("Reads checked: %0d, messages checked: %0d, errors: %0d",
             reads_checked, msgs_checked, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
